// File: logic/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// Width of one stored data word.
`define FIFO_DATA_W 8

// Width of a storage index into the array.
`define FIFO_ADDR_W 3

// Number of storage entries.
// Pointers carry one bit more than the address so that a full FIFO
// can be told apart from an empty one.
`define FIFO_DEPTH (1 << `FIFO_ADDR_W)

// Width of a pointer, binary or Gray.
`define FIFO_PTR_W (`FIFO_ADDR_W + 1)

`endif

// File: logic/fifo_pkg.sv
package fifo_pkg;

`include "fifo_consts.svh"

    typedef logic [`FIFO_DATA_W-1:0] data_t;

    typedef logic [`FIFO_ADDR_W-1:0] addr_t;

    // Gray-coded pointer with the extra wrap bit on top.
    typedef logic [`FIFO_PTR_W-1:0] ptr_t;

    // One write request into the storage array, already qualified with not-full.
    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } mem_wr_t;

    // Binary to Gray conversion shared by both pointer controllers.
    function automatic ptr_t to_gray(input logic [`FIFO_PTR_W-1:0] bin);
        return ptr_t'((bin >> 1) ^ bin);
    endfunction

endpackage

// File: logic/fifo_mem.sv
`timescale 1ns/1ns

`include "fifo_consts.svh"

module fifo_mem (
    input  logic             write_clk,
    input  fifo_pkg::mem_wr_t wr,
    input  fifo_pkg::addr_t  read_address,
    output fifo_pkg::data_t  read_data
);

    fifo_pkg::data_t mem [`FIFO_DEPTH];

    // The write controller has already masked the enable with not-full.
    always_ff @(posedge write_clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Asynchronous read port.
    // The read controller always points at the oldest word, which
    // gives the first-word fall-through behavior at the top level.
    // The address only moves on read_clk, so the output is stable
    // within the read domain except when the addressed entry is
    // written, and that only happens while the FIFO looks empty.
    assign read_data = mem[read_address];

endmodule

// File: logic/fifo_wr_ctrl.sv
`timescale 1ns/1ns

`include "fifo_consts.svh"

module fifo_wr_ctrl (
    input  logic              write_clk,
    input  logic              write_reset_n,
    input  logic              write_enable,
    input  fifo_pkg::data_t   write_data,
    input  fifo_pkg::ptr_t    sync_read_pointer,
    output fifo_pkg::ptr_t    write_pointer,
    output fifo_pkg::mem_wr_t wr,
    output logic              write_full
);

    logic [`FIFO_PTR_W-1:0] write_binary;
    logic [`FIFO_PTR_W-1:0] write_binary_next;
    fifo_pkg::ptr_t         write_gray_next;
    fifo_pkg::ptr_t         full_match;
    logic                   write_accept;

    assign write_accept      = write_enable & ~write_full;
    assign write_binary_next = write_binary + {{(`FIFO_PTR_W-1){1'b0}}, write_accept};
    assign write_gray_next   = fifo_pkg::to_gray(write_binary_next);

    // In Gray code a pointer that is exactly one lap ahead differs from
    // the other in its top two bits only.
    assign full_match = {~sync_read_pointer[`FIFO_PTR_W-1:`FIFO_PTR_W-2],
                         sync_read_pointer[`FIFO_PTR_W-3:0]};

    always_ff @(posedge write_clk or negedge write_reset_n) begin
        if (!write_reset_n) begin
            write_binary  <= '0;
            write_pointer <= '0;
        end else begin
            write_binary  <= write_binary_next;
            write_pointer <= write_gray_next;
        end
    end

    // Full is computed from the pointer after this edge, so it is
    // already valid in the cycle that follows the last free write.
    always_ff @(posedge write_clk or negedge write_reset_n) begin
        if (!write_reset_n) begin
            write_full <= 1'b0;
        end else begin
            write_full <= (write_gray_next == full_match);
        end
    end

    assign wr.en   = write_accept;
    assign wr.addr = write_binary[`FIFO_ADDR_W-1:0];
    assign wr.data = write_data;

endmodule

// File: logic/fifo_rd_ctrl.sv
`timescale 1ns/1ns

`include "fifo_consts.svh"

module fifo_rd_ctrl (
    input  logic            read_clk,
    input  logic            read_reset_n,
    input  logic            read_enable,
    input  fifo_pkg::ptr_t  sync_write_pointer,
    output fifo_pkg::ptr_t  read_pointer,
    output fifo_pkg::addr_t read_address,
    output logic            read_empty
);

    logic [`FIFO_PTR_W-1:0] read_binary;
    logic [`FIFO_PTR_W-1:0] read_binary_next;
    fifo_pkg::ptr_t         read_gray_next;
    logic                   read_accept;

    // A read is only taken when a word is known to be present.
    assign read_accept      = read_enable & ~read_empty;
    assign read_binary_next = read_binary + {{(`FIFO_PTR_W-1){1'b0}}, read_accept};
    assign read_gray_next   = fifo_pkg::to_gray(read_binary_next);

    always_ff @(posedge read_clk or negedge read_reset_n) begin
        if (!read_reset_n) begin
            read_binary  <= '0;
            read_pointer <= '0;
        end else begin
            read_binary  <= read_binary_next;
            read_pointer <= read_gray_next;
        end
    end

    // Empty when the pointer after this edge catches up with the
    // synchronized write pointer.
    // The write pointer seen here lags the real one, so the flag may
    // stay high a little too long but never drops early.
    always_ff @(posedge read_clk or negedge read_reset_n) begin
        if (!read_reset_n) begin
            read_empty <= 1'b1;
        end else begin
            read_empty <= (read_gray_next == sync_write_pointer);
        end
    end

    // The current read address names the oldest stored word.
    assign read_address = read_binary[`FIFO_ADDR_W-1:0];

endmodule

// File: logic/gray_sync.sv
`timescale 1ns/1ns

module gray_sync (
    input  logic           dst_clk,
    input  logic           dst_reset_n,
    input  fifo_pkg::ptr_t src_pointer,
    output fifo_pkg::ptr_t dst_pointer
);

    fifo_pkg::ptr_t meta_pointer;

    // Two flops in the destination domain.
    // The source pointer is Gray coded, so at most one bit is in motion
    // when it is sampled and the result is either the old or the new
    // pointer, never a mix of both.
    always_ff @(posedge dst_clk or negedge dst_reset_n) begin
        if (!dst_reset_n) begin
            meta_pointer <= '0;
            dst_pointer  <= '0;
        end else begin
            meta_pointer <= src_pointer;
            dst_pointer  <= meta_pointer;
        end
    end

endmodule

// File: logic/async_fifo.sv
`timescale 1ns/1ns

module async_fifo (
    input  logic            write_clk,
    input  logic            write_reset_n,
    input  logic            write_enable,
    input  fifo_pkg::data_t write_data,
    output logic            write_full,
    input  logic            read_clk,
    input  logic            read_reset_n,
    input  logic            read_enable,
    output fifo_pkg::data_t read_data,
    output logic            read_empty
);

    fifo_pkg::mem_wr_t wr;
    fifo_pkg::addr_t   read_address;
    fifo_pkg::ptr_t    write_pointer;
    fifo_pkg::ptr_t    read_pointer;
    fifo_pkg::ptr_t    sync_write_pointer;
    fifo_pkg::ptr_t    sync_read_pointer;

    fifo_mem u_fifo_mem (
        .write_clk    (write_clk),
        .wr           (wr),
        .read_address (read_address),
        .read_data    (read_data)
    );

    fifo_wr_ctrl u_fifo_wr_ctrl (
        .write_clk         (write_clk),
        .write_reset_n     (write_reset_n),
        .write_enable      (write_enable),
        .write_data        (write_data),
        .sync_read_pointer (sync_read_pointer),
        .write_pointer     (write_pointer),
        .wr                (wr),
        .write_full        (write_full)
    );

    fifo_rd_ctrl u_fifo_rd_ctrl (
        .read_clk           (read_clk),
        .read_reset_n       (read_reset_n),
        .read_enable        (read_enable),
        .sync_write_pointer (sync_write_pointer),
        .read_pointer       (read_pointer),
        .read_address       (read_address),
        .read_empty         (read_empty)
    );

    // Write pointer into the read domain, for the empty flag.
    gray_sync u_sync_to_read (
        .dst_clk     (read_clk),
        .dst_reset_n (read_reset_n),
        .src_pointer (write_pointer),
        .dst_pointer (sync_write_pointer)
    );

    // Read pointer into the write domain, for the full flag.
    gray_sync u_sync_to_write (
        .dst_clk     (write_clk),
        .dst_reset_n (write_reset_n),
        .src_pointer (read_pointer),
        .dst_pointer (sync_read_pointer)
    );

endmodule

// File: tests/async_fifo_sva.sv
`timescale 1ns/1ns

module async_fifo_sva (
    input logic           clk,
    input logic           reset_n,
    input fifo_pkg::ptr_t pointer,
    input logic           stall,
    input logic           stall_reset_value
);

    // A Gray pointer steps by one code at most, so one bit at most flips.
    gray_one_step: assert property (@(posedge clk) disable iff (!reset_n)
        $countones(pointer ^ $past(pointer)) <= 1)
        else $error("Gray pointer changed by more than one bit in one clock");

    // No transfer may happen while the side's flag blocks it.
    pointer_holds: assert property (@(posedge clk) disable iff (!reset_n)
        stall |=> $stable(pointer))
        else $error("Pointer moved while its full or empty flag was high");

    // The flag keeps its reset value through the first clock edge after reset.
    flag_after_reset: assert property (@(posedge clk)
        $rose(reset_n) |=> stall == stall_reset_value)
        else $error("Flag did not hold its reset value in the first cycle");

endmodule

bind fifo_wr_ctrl async_fifo_sva u_wr_sva (
    .clk               (write_clk),
    .reset_n           (write_reset_n),
    .pointer           (write_pointer),
    .stall             (write_full),
    .stall_reset_value (1'b0)
);

bind fifo_rd_ctrl async_fifo_sva u_rd_sva (
    .clk               (read_clk),
    .reset_n           (read_reset_n),
    .pointer           (read_pointer),
    .stall             (read_empty),
    .stall_reset_value (1'b1)
);

// File: tests/async_fifo_tb.sv
`timescale 1ns/1ns

`include "fifo_consts.svh"

module async_fifo_tb;

    logic            write_clk;
    logic            write_reset_n;
    logic            write_enable;
    fifo_pkg::data_t write_data;
    logic            write_full;
    logic            read_clk;
    logic            read_reset_n;
    logic            read_enable;
    fifo_pkg::data_t read_data;
    logic            read_empty;

    // Reference model of the stored words, oldest at the front.
    fifo_pkg::data_t model[$];

    // Accept decisions made after driving, applied at the next edge.
    logic            write_pending = 1'b0;
    fifo_pkg::data_t write_pending_data;
    logic            read_pending = 1'b0;

    logic            random_done = 1'b0;
    logic [31:0]     lcg_state = 32'd61;
    string           phase = "reset";

    async_fifo u_async_fifo (
        .write_clk     (write_clk),
        .write_reset_n (write_reset_n),
        .write_enable  (write_enable),
        .write_data    (write_data),
        .write_full    (write_full),
        .read_clk      (read_clk),
        .read_reset_n  (read_reset_n),
        .read_enable   (read_enable),
        .read_data     (read_data),
        .read_empty    (read_empty)
    );

    initial begin
        read_clk = 1'b0;
        forever #20 read_clk = ~read_clk;
    end

    // The write clock starts 5 ns late so that no edge or drive time
    // of one domain ever lines up with the other.
    initial begin
        write_clk = 1'b0;
        #5;
        forever #14 write_clk = ~write_clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = next_rand();
        return r[22];
    endfunction

    function automatic fifo_pkg::data_t random_word();
        logic [31:0] r;
        r = next_rand();
        return fifo_pkg::data_t'(r >> 16);
    endfunction

    task automatic stop_on_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string check, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error: test %s, %s: expected 0x%0h, actual 0x%0h",
                 phase, check, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_problem(input string what);
        $display("test %s: %s", phase, what);
        stop_on_failure();
    endtask

    task automatic check_value(input string check, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else report_mismatch(check, expected, actual);
    endtask

    // One write_clk cycle. The word driven last cycle is pushed if it was accepted.
    task automatic write_cycle(input logic enable, input fifo_pkg::data_t data);
        @(posedge write_clk);
        if (write_pending) begin
            model.push_back(write_pending_data);
        end
        #2;
        write_enable = enable;
        write_data   = data;
        write_pending      = enable && !write_full;
        write_pending_data = data;
        assert (model.size() <= `FIFO_DEPTH)
            else report_problem("the FIFO accepted more words than it can hold");
    endtask

    // One read_clk cycle. The word shown last cycle is popped if it was consumed.
    task automatic read_cycle(input logic enable);
        @(posedge read_clk);
        if (read_pending) begin
            void'(model.pop_front());
        end
        #2;
        read_enable = enable;
        if (!read_empty) begin
            assert (model.size() > 0)
                else report_problem("read_empty was low while no word was stored");
            check_value("read data", 32'(model[0]), 32'(read_data));
        end
        read_pending = enable && !read_empty;
    endtask

    task automatic fill_until_full();
        int cycles;
        cycles = 0;
        do begin
            write_cycle(1'b1, random_word());
            check_value("full flag", 32'(model.size() >= `FIFO_DEPTH), 32'(write_full));
            cycles++;
        end while (!write_full && cycles < 200);
        assert (write_full)
            else report_problem("write_full never went high while filling");
        // These writes hit a full FIFO and must vanish.
        repeat (4) begin
            write_cycle(1'b1, random_word());
            check_value("stored words", 32'(`FIFO_DEPTH), 32'(model.size()));
        end
        write_cycle(1'b0, '0);
    endtask

    task automatic drain_all();
        int cycles;
        // Give the last write pointer time to cross into the read domain.
        repeat (4) read_cycle(1'b0);
        cycles = 0;
        do begin
            read_cycle(1'b1);
            check_value("empty flag", 32'(model.size() == 0), 32'(read_empty));
            cycles++;
        end while (!read_empty && cycles < 200);
        assert (read_empty)
            else report_problem("read_empty never went high while draining");
        check_value("stored words", 32'd0, 32'(model.size()));
        read_cycle(1'b0);
    endtask

    task automatic wait_for_space();
        int cycles;
        cycles = 0;
        while (write_full && cycles < 200) begin
            write_cycle(1'b0, '0);
            cycles++;
        end
        assert (!write_full)
            else report_problem("write_full never went low after the drain");
    endtask

    task automatic run_random_traffic();
        int cycles;
        fork
            begin
                for (cycles = 0; cycles < 2000; cycles++) begin
                    read_cycle(random_bit());
                end
                random_done = 1'b1;
            end
            begin
                while (!random_done) begin
                    write_cycle(random_bit(), random_word());
                end
            end
        join
        write_cycle(1'b0, '0);
        read_cycle(1'b0);
    endtask

    initial begin
        write_enable  = 1'b0;
        write_data    = '0;
        read_enable   = 1'b0;
        write_reset_n = 1'b0;
        read_reset_n  = 1'b0;
        repeat (8) @(posedge read_clk);
        #2;
        read_reset_n = 1'b1;
        @(posedge write_clk);
        #2;
        write_reset_n = 1'b1;

        check_value("empty after reset", 32'd1, 32'(read_empty));
        check_value("full after reset", 32'd0, 32'(write_full));

        phase = "fill";
        fill_until_full();
        phase = "drain";
        drain_all();
        wait_for_space();
        phase = "random";
        run_random_traffic();
        phase = "final drain";
        drain_all();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: files.f
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_mem.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/gray_sync.sv
logic/async_fifo.sv
tests/async_fifo_sva.sv
tests/async_fifo_tb.sv

// File: Makefile
TOP     = async_fifo_tb
SOURCES = $(wildcard logic/*.sv logic/*.svh tests/*.sv) files.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ns -j 0 --top-module $(TOP) -f files.f

# A crash or an assertion stop without the testbench's own message still
# counts as a failure, so the message is added to the log in that case.
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
	cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log
